//--- Makefile
TOOL       = verilator
TOP        = tb_sa_top
FILELIST   = sim.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/sa_cfg.svh
`ifndef SA_CFG_SVH
`define SA_CFG_SVH

// array dimension, a power of two of at least 2
`define SA_N 4

// signed operand width
`define SA_DATA_W 16

// partial sum width, wide enough for SA_N full-scale products
`define SA_PSUM_W 40

// row and column index width
`define SA_IDX_W ($clog2(`SA_N))

// words per lane buffer, one column of A
`define SA_BUF_DEPTH `SA_N

`endif

//--- design/sa_ctrl.sv
`timescale 1ns/10ps
`include "sa_cfg.svh"

module sa_ctrl (
    input  logic                   s_clk,
    input  logic                   s_rst,
    input  logic                   start,
    input  logic                   a_valid,
    input  logic                   a_done,
    input  logic                   b_valid,
    input  logic                   b_done,
    output logic                   a_ready,
    output logic                   b_ready,
    output logic [`SA_N*`SA_N-1:0] weight_we,
    output logic                   a_we,
    output logic                   feed_go,
    input  logic                   feed_end,
    input  logic                   in_flight,
    output logic                   busy,
    output logic                   done
);

    sa_pkg::sa_state_t      state;
    sa_pkg::sa_state_t      state_nxt;
    logic [`SA_N*`SA_N-1:0] w_ptr;
    logic                   b_we;
    logic                   a_last;
    logic                   b_last;
    logic                   a_seen;
    logic                   b_seen;

    assign a_we      = a_valid & a_ready;
    assign b_we      = b_valid & b_ready;
    assign a_last    = a_we & a_done;
    assign b_last    = b_we & b_done;
    assign weight_we = b_we ? w_ptr : '0;
    assign feed_go   = (state == sa_pkg::ST_LOAD) && a_seen && b_seen;
    assign busy      = (state != sa_pkg::ST_IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            sa_pkg::ST_IDLE:  if (start) state_nxt = sa_pkg::ST_LOAD;
            sa_pkg::ST_LOAD:  if (feed_go) state_nxt = sa_pkg::ST_FEED;
            sa_pkg::ST_FEED:  if (feed_end) state_nxt = sa_pkg::ST_DRAIN;
            sa_pkg::ST_DRAIN: if (!in_flight) state_nxt = sa_pkg::ST_IDLE;
            default:          state_nxt = sa_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state <= sa_pkg::ST_IDLE;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= (state == sa_pkg::ST_DRAIN) && !in_flight;
        end
    end

    // ready drops right after its own last word
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            a_ready <= 1'b0;
            b_ready <= 1'b0;
        end else begin
            a_ready <= !a_last && (state == sa_pkg::ST_LOAD) && !a_seen;
            b_ready <= !b_last && (state == sa_pkg::ST_LOAD) && !b_seen;
        end
    end

    // done-seen flags and weight slot pointer, rearmed in idle
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            a_seen <= 1'b0;
            b_seen <= 1'b0;
            w_ptr  <= (`SA_N*`SA_N)'(1);
        end else if (state == sa_pkg::ST_IDLE) begin
            a_seen <= 1'b0;
            b_seen <= 1'b0;
            w_ptr  <= (`SA_N*`SA_N)'(1);
        end else begin
            if (a_last) a_seen <= 1'b1;
            if (b_last) b_seen <= 1'b1;
            if (b_we) w_ptr <= w_ptr << 1;
        end
    end

endmodule

//--- design/sa_feed_timer.sv
`timescale 1ns/10ps
`include "sa_cfg.svh"

module sa_feed_timer (
    input  logic             s_clk,
    input  logic             s_rst,
    input  logic             go,
    output logic [`SA_N-1:0] rd,
    output sa_pkg::sa_idx_t  tag,
    output logic             feed_end
);

    localparam sa_pkg::sa_idx_t ROW_LAST = sa_pkg::sa_idx_t'(`SA_N - 1);

    logic             run;
    logic [`SA_N-1:1] chain;

    assign rd = {chain, run};

    // lane 0 strobe, one row per cycle
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            run <= 1'b0;
            tag <= '0;
        end else if (go) begin
            run <= 1'b1;
            tag <= '0;
        end else if (run) begin
            tag <= tag + sa_pkg::sa_idx_t'(1);
            if (tag == ROW_LAST) begin
                run <= 1'b0;
            end
        end
    end

    // each lane trails its upper neighbour by one cycle
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            chain    <= '0;
            feed_end <= 1'b0;
        end else begin
            chain[1] <= run;
            for (int r = 2; r < `SA_N; r++) begin
                chain[r] <= chain[r-1];
            end
            // last lane still reading while the one above has stopped
            feed_end <= rd[`SA_N-1] & ~rd[`SA_N-2];
        end
    end

endmodule

//--- design/sa_lane_buffer.sv
`timescale 1ns/10ps
`include "sa_cfg.svh"

module sa_lane_buffer (
    input  logic                         s_clk,
    input  logic                         s_rst,
    input  logic                         we,
    input  sa_pkg::sa_data_t             wdata,
    input  logic [`SA_N-1:0]             rd,
    output sa_pkg::sa_data_t [`SA_N-1:0] rdata,
    output logic [`SA_N-1:0]             rvalid
);

    localparam sa_pkg::sa_idx_t IDX_LAST = sa_pkg::sa_idx_t'(`SA_BUF_DEPTH - 1);
    localparam sa_pkg::sa_idx_t IDX_STEP = sa_pkg::sa_idx_t'(1);

    // lane that takes the next word of A
    sa_pkg::sa_idx_t wr_lane;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_lane <= '0;
            rvalid  <= '0;
        end else begin
            if (we) begin
                wr_lane <= wr_lane + IDX_STEP;
            end
            rvalid <= rd;
        end
    end

    for (genvar r = 0; r < `SA_N; r++) begin : g_lane
        sa_pkg::sa_data_t mem [`SA_BUF_DEPTH];
        sa_pkg::sa_data_t q;
        sa_pkg::sa_idx_t  wr_idx;
        sa_pkg::sa_idx_t  rd_idx;
        logic             lane_we;

        assign lane_we  = we && (wr_lane == sa_pkg::sa_idx_t'(r));
        assign rdata[r] = q;

        // both indices rewind once a full column has been read
        always_ff @(posedge s_clk or posedge s_rst) begin
            if (s_rst) begin
                wr_idx <= '0;
                rd_idx <= '0;
            end else if (rd[r] && rd_idx == IDX_LAST) begin
                wr_idx <= '0;
                rd_idx <= '0;
            end else begin
                if (lane_we) begin
                    wr_idx <= wr_idx + IDX_STEP;
                end
                if (rd[r]) begin
                    rd_idx <= rd_idx + IDX_STEP;
                end
            end
        end

        always_ff @(posedge s_clk) begin
            if (lane_we) begin
                mem[wr_idx] <= wdata;
            end
            if (rd[r]) begin
                q <= mem[rd_idx];
            end
        end
    end

endmodule

//--- design/sa_pe.sv
`timescale 1ns/10ps
`include "sa_cfg.svh"

module sa_pe (
    input  logic             s_clk,
    input  logic             s_rst,
    input  logic             w_we,
    input  sa_pkg::sa_data_t w_data,
    input  sa_pkg::sa_data_t a_in,
    input  logic             a_in_valid,
    output sa_pkg::sa_data_t a_out,
    output logic             a_out_valid,
    input  sa_pkg::sa_flow_t flow_in,
    output sa_pkg::sa_flow_t flow_out
);

    sa_pkg::sa_data_t weight;
    sa_pkg::sa_psum_t prod;

    // full signed product, sign extended before the multiply
    assign prod = sa_pkg::sa_psum_t'(a_in) * sa_pkg::sa_psum_t'(weight);

    always_ff @(posedge s_clk) begin
        if (w_we) begin
            weight <= w_data;
        end
        a_out <= a_in;
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            a_out_valid <= 1'b0;
            flow_out    <= '0;
        end else begin
            a_out_valid    <= a_in_valid;
            flow_out.valid <= flow_in.valid;
            // tag rides along with the sum it belongs to
            if (a_in_valid) begin
                flow_out.tag <= flow_in.tag;
                flow_out.sum <= flow_in.sum + prod;
            end
        end
    end

endmodule

//--- design/sa_pe_array.sv
`timescale 1ns/10ps
`include "sa_cfg.svh"

module sa_pe_array (
    input  logic                             s_clk,
    input  logic                             s_rst,
    input  logic [`SA_N*`SA_N-1:0]           weight_we,
    input  sa_pkg::sa_data_t                 w_data,
    input  sa_pkg::sa_data_t [`SA_N-1:0]     lane_data,
    input  logic [`SA_N-1:0]                 lane_valid,
    input  sa_pkg::sa_idx_t                  lane_tag,
    output sa_pkg::sa_flow_t [`SA_N-1:0]     flow_out,
    output logic                             in_flight
);

    // horizontal operand links, one extra column at the right edge
    sa_pkg::sa_data_t a_link [`SA_N][`SA_N+1];
    logic             v_link [`SA_N][`SA_N+1];
    // vertical token links, row 0 is the injected token
    sa_pkg::sa_flow_t f_link [`SA_N+1][`SA_N];

    sa_pkg::sa_idx_t  tag_q;
    logic [`SA_N-1:1] inj_v_q;
    sa_pkg::sa_idx_t  inj_t_q [`SA_N-1:1];

    // tag lines up with the registered buffer read
    always_ff @(posedge s_clk) begin
        tag_q      <= lane_tag;
        inj_t_q[1] <= tag_q;
        for (int c = 2; c < `SA_N; c++) begin
            inj_t_q[c] <= inj_t_q[c-1];
        end
    end

    // token skew across the top row, one cycle per column
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            inj_v_q <= '0;
        end else begin
            inj_v_q[1] <= lane_valid[0];
            for (int c = 2; c < `SA_N; c++) begin
                inj_v_q[c] <= inj_v_q[c-1];
            end
        end
    end

    for (genvar r = 0; r < `SA_N; r++) begin : g_row
        assign a_link[r][0] = lane_data[r];
        assign v_link[r][0] = lane_valid[r];

        for (genvar c = 0; c < `SA_N; c++) begin : g_col
            if (r == 0) begin : g_inj
                if (c == 0) begin : g_head
                    assign f_link[0][0] = '{valid: lane_valid[0], tag: tag_q, sum: '0};
                end else begin : g_skew
                    assign f_link[0][c] = '{valid: inj_v_q[c], tag: inj_t_q[c], sum: '0};
                end
            end

            sa_pe i_pe (
                .s_clk       (s_clk),
                .s_rst       (s_rst),
                .w_we        (weight_we[r*`SA_N+c]),
                .w_data      (w_data),
                .a_in        (a_link[r][c]),
                .a_in_valid  (v_link[r][c]),
                .a_out       (a_link[r][c+1]),
                .a_out_valid (v_link[r][c+1]),
                .flow_in     (f_link[r][c]),
                .flow_out    (f_link[r+1][c])
            );
        end
    end

    // bottom row taps
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            flow_out <= '0;
        end else begin
            for (int c = 0; c < `SA_N; c++) begin
                flow_out[c] <= f_link[`SA_N][c];
            end
        end
    end

    always_comb begin
        in_flight = |lane_valid;
        for (int c = 0; c < `SA_N; c++) begin
            in_flight = in_flight | flow_out[c].valid | f_link[0][c].valid;
        end
        for (int r = 0; r < `SA_N; r++) begin
            for (int c = 0; c < `SA_N; c++) begin
                in_flight = in_flight | v_link[r][c+1] | f_link[r+1][c].valid;
            end
        end
    end

endmodule

//--- design/sa_pkg.sv
`include "sa_cfg.svh"

package sa_pkg;

    typedef logic signed [`SA_DATA_W-1:0] sa_data_t;
    typedef logic signed [`SA_PSUM_W-1:0] sa_psum_t;
    typedef logic [`SA_IDX_W-1:0] sa_idx_t;

    // job sequence
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_FEED,
        ST_DRAIN
    } sa_state_t;

    // token moving down a column
    typedef struct packed {
        logic     valid;
        sa_idx_t  tag;
        sa_psum_t sum;
    } sa_flow_t;

    typedef struct packed {
        sa_idx_t  row;
        sa_idx_t  col;
        sa_psum_t value;
    } sa_result_t;

endpackage

//--- design/sa_top.sv
`timescale 1ns/10ps
`include "sa_cfg.svh"

module sa_top (
    input  logic                           s_clk,
    input  logic                           s_rst,
    input  logic                           b_valid,
    input  sa_pkg::sa_data_t               b_data,
    input  logic                           b_done,
    output logic                           b_ready,
    input  logic                           a_valid,
    input  sa_pkg::sa_data_t               a_data,
    input  logic                           a_done,
    output logic                           a_ready,
    input  logic                           start,
    output logic                           busy,
    output logic [`SA_N-1:0]               res_valid,
    output sa_pkg::sa_result_t [`SA_N-1:0] res,
    output logic                           done
);

    logic [`SA_N*`SA_N-1:0]       weight_we;
    logic                         a_we;
    logic                         feed_go;
    logic                         feed_end;
    logic [`SA_N-1:0]             lane_rd;
    sa_pkg::sa_idx_t              lane_tag;
    sa_pkg::sa_data_t [`SA_N-1:0] lane_data;
    logic [`SA_N-1:0]             lane_valid;
    sa_pkg::sa_flow_t [`SA_N-1:0] flow_out;
    logic                         in_flight;

    sa_ctrl i_ctrl (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .start     (start),
        .a_valid   (a_valid),
        .a_done    (a_done),
        .b_valid   (b_valid),
        .b_done    (b_done),
        .a_ready   (a_ready),
        .b_ready   (b_ready),
        .weight_we (weight_we),
        .a_we      (a_we),
        .feed_go   (feed_go),
        .feed_end  (feed_end),
        .in_flight (in_flight),
        .busy      (busy),
        .done      (done)
    );

    sa_feed_timer i_timer (
        .s_clk    (s_clk),
        .s_rst    (s_rst),
        .go       (feed_go),
        .rd       (lane_rd),
        .tag      (lane_tag),
        .feed_end (feed_end)
    );

    sa_lane_buffer i_buf (
        .s_clk  (s_clk),
        .s_rst  (s_rst),
        .we     (a_we),
        .wdata  (a_data),
        .rd     (lane_rd),
        .rdata  (lane_data),
        .rvalid (lane_valid)
    );

    sa_pe_array i_array (
        .s_clk      (s_clk),
        .s_rst      (s_rst),
        .weight_we  (weight_we),
        .w_data     (b_data),
        .lane_data  (lane_data),
        .lane_valid (lane_valid),
        .lane_tag   (lane_tag),
        .flow_out   (flow_out),
        .in_flight  (in_flight)
    );

    // column index comes from the tap position
    for (genvar c = 0; c < `SA_N; c++) begin : g_res
        assign res_valid[c] = flow_out[c].valid;
        assign res[c] = '{row: flow_out[c].tag, col: sa_pkg::sa_idx_t'(c),
                          value: flow_out[c].sum};
    end

endmodule

//--- sim.f
+incdir+design
design/sa_pkg.sv
design/sa_pe.sv
design/sa_pe_array.sv
design/sa_lane_buffer.sv
design/sa_feed_timer.sv
design/sa_ctrl.sv
design/sa_top.sv
tests/tb_sa_top.sv

//--- tests/tb_sa_top.sv
`timescale 1ns/10ps
`include "sa_cfg.svh"

module tb_sa_top;

    localparam int N = `SA_N;
    localparam int NN = `SA_N * `SA_N;
    localparam int NJOB = 6;
    localparam int TIMEOUT = 200;
    localparam time CLK_PERIOD = 100;
    localparam time DRV = 10;
    localparam int MODE_FIXED = 0;
    localparam int MODE_RANDOM = 1;

    logic                           s_clk;
    logic                           s_rst;
    logic                           b_valid;
    sa_pkg::sa_data_t               b_data;
    logic                           b_done;
    logic                           b_ready;
    logic                           a_valid;
    sa_pkg::sa_data_t               a_data;
    logic                           a_done;
    logic                           a_ready;
    logic                           start;
    logic                           busy;
    logic [`SA_N-1:0]               res_valid;
    sa_pkg::sa_result_t [`SA_N-1:0] res;
    logic                           done;

    // job table and the expected C from the reference model
    int               job_mode [NJOB] = '{MODE_FIXED, MODE_FIXED, MODE_FIXED, MODE_FIXED,
                                          MODE_RANDOM, MODE_RANDOM};
    // cycles by which A trails B (B trails when negative)
    int               job_lag [NJOB] = '{0, 6, -6, 0, 3, -2};
    sa_pkg::sa_data_t job_a [NJOB][N][N];
    sa_pkg::sa_data_t job_b [NJOB][N][N];
    sa_pkg::sa_psum_t job_c [NJOB][N][N];

    logic [15:0] lfsr;
    logic [63:0] gap_a;
    logic [63:0] gap_b;

    sa_top i_dut (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .b_valid   (b_valid),
        .b_data    (b_data),
        .b_done    (b_done),
        .b_ready   (b_ready),
        .a_valid   (a_valid),
        .a_data    (a_data),
        .a_done    (a_done),
        .a_ready   (a_ready),
        .start     (start),
        .busy      (busy),
        .res_valid (res_valid),
        .res       (res),
        .done      (done)
    );

    initial begin
        s_clk = 1'b0;
        forever #(CLK_PERIOD / 2) s_clk = ~s_clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [63:0] rand_bits(input int nbits);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < nbits; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            abort($sformatf("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, want));
        end
    endtask

    task automatic check_result(input sa_pkg::sa_result_t got, input sa_pkg::sa_result_t want,
                                input string what);
        if (got !== want) begin
            abort($sformatf("ERROR at %0d ns: %s row %0d col %0d value %0d, expected %0d %0d %0d",
                            $time, what, got.row, got.col, got.value,
                            want.row, want.col, want.value));
        end
    endtask

    task automatic fill_job_table();
        for (int j = 0; j < NJOB; j++) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N; c++) begin
                    case (j)
                        // identity weights give C equal to A
                        0: begin
                            job_a[j][r][c] = sa_pkg::sa_data_t'(r * N + c + 1);
                            job_b[j][r][c] = sa_pkg::sa_data_t'((r == c) ? 1 : 0);
                        end
                        1: begin
                            job_a[j][r][c] = sa_pkg::sa_data_t'(r - 2 * c);
                            job_b[j][r][c] = sa_pkg::sa_data_t'(3 * r + c - 5);
                        end
                        // every sum is 2**32 and needs more than 32 bits
                        2: begin
                            job_a[j][r][c] = sa_pkg::sa_data_t'(-32768);
                            job_b[j][r][c] = sa_pkg::sa_data_t'(-32768);
                        end
                        3: begin
                            job_a[j][r][c] = sa_pkg::sa_data_t'(((r + c) % 2) ? 32767 : -32768);
                            job_b[j][r][c] = sa_pkg::sa_data_t'((c < N / 2) ? -32768 : 32767);
                        end
                        default: begin
                            job_a[j][r][c] = sa_pkg::sa_data_t'(rand_bits(16));
                            job_b[j][r][c] = sa_pkg::sa_data_t'(rand_bits(16));
                        end
                    endcase
                end
            end
        end
    endtask

    // reference model in 64-bit integer arithmetic
    task automatic compute_expected();
        longint acc;
        for (int j = 0; j < NJOB; j++) begin
            for (int i = 0; i < N; i++) begin
                for (int c = 0; c < N; c++) begin
                    acc = 0;
                    for (int r = 0; r < N; r++) begin
                        acc += longint'(job_a[j][i][r]) * longint'(job_b[j][r][c]);
                    end
                    job_c[j][i][c] = sa_pkg::sa_psum_t'(acc);
                end
            end
        end
    endtask

    task automatic load_stream(input bit is_a, input int j);
        int               k;
        int               idle;
        int               cyc;
        int               lead;
        bit               gap;
        logic             rdy;
        sa_pkg::sa_data_t word;
        k = 0;
        idle = 0;
        cyc = 0;
        lead = is_a ? job_lag[j] : -job_lag[j];
        if (lead > 0) begin
            repeat (lead) @(posedge s_clk);
        end
        while (k < NN) begin
            @(posedge s_clk);
            #DRV;
            gap = is_a ? gap_a[cyc % 64] : gap_b[cyc % 64];
            word = is_a ? job_a[j][k / N][k % N] : job_b[j][k / N][k % N];
            // registered ready holds until the coming edge
            rdy = is_a ? a_ready : b_ready;
            if (is_a) begin
                a_valid = !gap;
                a_data = word;
                a_done = (k == NN - 1);
            end else begin
                b_valid = !gap;
                b_data = word;
                b_done = (k == NN - 1);
            end
            if (!gap && rdy) begin
                k++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    abort(is_a ? "timeout: A load stalled, a_ready never came"
                               : "timeout: B load stalled, b_ready never came");
                end
            end
            cyc++;
        end
        // a word offered after done must not be taken
        repeat (2) begin
            @(posedge s_clk);
            #DRV;
            if (is_a) begin
                a_valid = 1'b1;
                a_data = sa_pkg::sa_data_t'(16'h5a5a);
                a_done = 1'b0;
            end else begin
                b_valid = 1'b1;
                b_data = sa_pkg::sa_data_t'(16'h5a5a);
                b_done = 1'b0;
            end
            check_flag(is_a ? a_ready : b_ready, 1'b0, "ready after its done word");
        end
        @(posedge s_clk);
        #DRV;
        if (is_a) begin
            a_valid = 1'b0;
        end else begin
            b_valid = 1'b0;
        end
    endtask

    // the first result shows that the job is past its loads
    task automatic wait_first_result();
        int idle;
        idle = 0;
        while (res_valid == '0) begin
            @(posedge s_clk);
            #DRV;
            idle++;
            if (idle > TIMEOUT) begin
                abort("timeout: no result came before the second start pulse");
            end
        end
    endtask

    task automatic collect_results(input int j);
        bit                 seen [N][N];
        int                 cnt;
        int                 idle;
        bit                 fin;
        sa_pkg::sa_result_t want;
        seen = '{default: 1'b0};
        cnt = 0;
        idle = 0;
        fin = 1'b0;
        while (!fin) begin
            @(posedge s_clk);
            #DRV;
            for (int c = 0; c < N; c++) begin
                if (res_valid[c]) begin
                    want.row = res[c].row;
                    want.col = sa_pkg::sa_idx_t'(c);
                    want.value = job_c[j][res[c].row][c];
                    check_flag(seen[res[c].row][c], 1'b0, "repeated result");
                    check_result(res[c], want, "result");
                    seen[res[c].row][c] = 1'b1;
                    cnt++;
                    idle = 0;
                end
            end
            if (done) begin
                fin = 1'b1;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    abort("timeout: the job never finished, no done pulse");
                end
            end
        end
        check_flag(cnt == NN, 1'b1, "all results in before done");
    endtask

    task automatic run_job(input int j);
        gap_a = (job_mode[j] == MODE_RANDOM) ? rand_bits(64) : '0;
        gap_b = (job_mode[j] == MODE_RANDOM) ? rand_bits(64) : '0;
        @(posedge s_clk);
        #DRV;
        start = 1'b1;
        @(posedge s_clk);
        #DRV;
        start = 1'b0;
        check_flag(busy, 1'b1, "busy after start");
        fork
            load_stream(1'b1, j);
            load_stream(1'b0, j);
            collect_results(j);
            // start while busy must be ignored
            begin
                wait_first_result();
                start = 1'b1;
                @(posedge s_clk);
                #DRV;
                start = 1'b0;
            end
        join
        @(posedge s_clk);
        #DRV;
        check_flag(done, 1'b0, "done one cycle after its pulse");
        check_flag(busy, 1'b0, "busy after done");
        check_flag(|res_valid, 1'b0, "res_valid after done");
    endtask

    initial begin
        lfsr = 16'd15401;
        s_rst = 1'b1;
        start = 1'b0;
        a_valid = 1'b0;
        a_data = '0;
        a_done = 1'b0;
        b_valid = 1'b0;
        b_data = '0;
        b_done = 1'b0;
        fill_job_table();
        compute_expected();
        repeat (3) @(posedge s_clk);
        #DRV;
        s_rst = 1'b0;
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(a_ready, 1'b0, "a_ready after reset");
        check_flag(b_ready, 1'b0, "b_ready after reset");
        check_flag(|res_valid, 1'b0, "res_valid after reset");
        for (int j = 0; j < NJOB; j++) begin
            run_job(j);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
